/* source/lane_pkg.sv */
package lane_pkg;

   // byte lanes in, packed words out
   localparam int BYTE_W = 8;
   localparam int BYTES_PER_WORD = 4;
   localparam int WORD_W = BYTE_W * BYTES_PER_WORD;

   // round-robin lane set
   localparam int NUM_LANES = 4;
   localparam int LANE_IDX_W = $clog2(NUM_LANES);

   // per-lane FIFO, addressed in bytes
   // 6 bits gives 64 bytes, i.e. 16 words
   localparam int FIFO_ADDR_W = 6;

   // level counts bytes and must reach the full depth
   localparam int LEVEL_W = FIFO_ADDR_W + 1;

endpackage

/* source/ram_2p_asym.sv */
`timescale 1ns/1ps

module ram_2p_asym #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   // address width in units of the narrower port
   parameter int ADDR_W = 6,
   localparam int MAX_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MIN_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int RATIO = MAX_W / MIN_W,
   localparam int W_ADDR_W = (W_DATA_W == MAX_W) ? ADDR_W - $clog2(RATIO) : ADDR_W,
   localparam int R_ADDR_W = (R_DATA_W == MAX_W) ? ADDR_W - $clog2(RATIO) : ADDR_W
) (
   input  logic                clk_i,

   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,

   input  logic                r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;
   // narrow slots touched per access on each side
   localparam int W_N = W_DATA_W / MIN_W;
   localparam int R_N = R_DATA_W / MIN_W;

   logic [MIN_W-1:0] mem [DEPTH];

   // wide writes split low-first over consecutive slots
   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         for (int i = 0; i < W_N; i++) begin
            mem[W_N * int'(w_addr_i) + i] <= w_data_i[i*MIN_W +: MIN_W];
         end
      end
   end

   // registered read, first slot lands in the low bits
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         for (int i = 0; i < R_N; i++) begin
            r_data_o[i*MIN_W +: MIN_W] <= mem[R_N * int'(r_addr_i) + i];
         end
      end
   end

   // an enabled port needs a known address inside the slot array
   a_w_addr_range: assert property (@(posedge clk_i)
      w_en_i |-> !$isunknown(w_addr_i) && (W_N * int'(w_addr_i) + W_N <= DEPTH))
      else $error("ram_2p_asym: write address out of range");

   a_r_addr_range: assert property (@(posedge clk_i)
      r_en_i |-> !$isunknown(r_addr_i) && (R_N * int'(r_addr_i) + R_N <= DEPTH))
      else $error("ram_2p_asym: read address out of range");

endmodule

/* source/asym_fifo.sv */
`timescale 1ns/1ps

module asym_fifo #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   // depth in units of the narrower side
   parameter int ADDR_W = 6,
   localparam int MAX_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MIN_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int RATIO = MAX_W / MIN_W,
   localparam int W_ADDR_W = (W_DATA_W == MAX_W) ? ADDR_W - $clog2(RATIO) : ADDR_W,
   localparam int R_ADDR_W = (R_DATA_W == MAX_W) ? ADDR_W - $clog2(RATIO) : ADDR_W
) (
   input  logic                clk_i,
   input  logic                rst_i,

   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,

   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,

   output logic [ADDR_W:0]     level_o
);

   localparam int LVL_W = ADDR_W + 1;
   localparam logic [ADDR_W:0] FIFO_SIZE = LVL_W'(1) << ADDR_W;

   // the wide side moves RATIO slots per access
   localparam logic [ADDR_W:0] W_INCR = (W_DATA_W > R_DATA_W) ? LVL_W'(RATIO) : LVL_W'(1);
   localparam logic [ADDR_W:0] R_INCR = (R_DATA_W > W_DATA_W) ? LVL_W'(RATIO) : LVL_W'(1);

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W:0]     level_q;
   logic [ADDR_W:0]     level_nxt;

   // registered flags gate the strobes directly
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   // address counters wrap at their own widths
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   always_comb begin
      level_nxt = level_q;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   // flags follow the next level and settle on the same edge
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_q   <= level_nxt;
         r_empty_o <= level_nxt < R_INCR;
         w_full_o  <= level_nxt > (FIFO_SIZE - W_INCR);
      end
   end

   assign level_o = level_q;

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) ram_i (
      .clk_i    (clk_i),
      .w_en_i   (w_en_int),
      .w_addr_i (w_addr),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_int),
      .r_addr_i (r_addr),
      .r_data_o (r_data_o)
   );

   // never more than the array holds
   a_level_max: assert property (@(posedge clk_i) disable iff (rst_i)
      level_q <= FIFO_SIZE)
      else $error("asym_fifo: level above depth");

   // a read only passes with a whole word stored
   a_level_min: assert property (@(posedge clk_i) disable iff (rst_i)
      r_en_int |-> level_q >= R_INCR)
      else $error("asym_fifo: read would underflow level");

endmodule

/* source/lane_dispatch.sv */
`timescale 1ns/1ps

module lane_dispatch (
   input  logic                            clk_i,
   input  logic                            rst_i,

   input  logic                            in_valid_i,
   input  logic [lane_pkg::BYTE_W-1:0]     in_data_i,
   output logic                            in_full_o,

   input  logic [lane_pkg::NUM_LANES-1:0]  lane_full_i,
   output logic [lane_pkg::NUM_LANES-1:0]  lane_w_en_o,
   output logic [lane_pkg::BYTE_W-1:0]     lane_w_data_o
);

   localparam logic [lane_pkg::LANE_IDX_W-1:0] LAST_LANE =
      lane_pkg::LANE_IDX_W'(lane_pkg::NUM_LANES - 1);

   logic [lane_pkg::LANE_IDX_W-1:0] wr_ptr;
   logic                            accept;

   // back-pressure comes from the lane next in line only
   assign in_full_o = lane_full_i[wr_ptr];
   assign accept    = in_valid_i & ~in_full_o;

   // one strobe, to the target lane
   always_comb begin
      lane_w_en_o = '0;
      if (accept) begin
         lane_w_en_o[wr_ptr] = 1'b1;
      end
   end

   // byte bus is shared, the strobe picks the lane
   assign lane_w_data_o = in_data_i;

   // pointer holds on a dropped byte
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
      end else if (accept) begin
         if (wr_ptr == LAST_LANE) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

endmodule

/* source/lane_collect.sv */
`timescale 1ns/1ps

module lane_collect (
   input  logic                                          clk_i,
   input  logic                                          rst_i,

   input  logic                                          out_en_i,
   output logic                                          out_empty_o,
   output logic [lane_pkg::WORD_W-1:0]                   out_data_o,
   output logic [lane_pkg::LANE_IDX_W-1:0]               out_lane_o,
   output logic                                          out_valid_o,

   input  logic [lane_pkg::NUM_LANES-1:0]                lane_empty_i,
   input  logic [lane_pkg::NUM_LANES*lane_pkg::WORD_W-1:0] lane_r_data_i,
   output logic [lane_pkg::NUM_LANES-1:0]                lane_r_en_o
);

   localparam logic [lane_pkg::LANE_IDX_W-1:0] LAST_LANE =
      lane_pkg::LANE_IDX_W'(lane_pkg::NUM_LANES - 1);

   logic [lane_pkg::LANE_IDX_W-1:0] rd_ptr;
   logic [lane_pkg::LANE_IDX_W-1:0] rd_lane_q;
   logic                            rd_valid_q;
   logic                            accept;

   // strict order, an empty target blocks the others
   assign out_empty_o = lane_empty_i[rd_ptr];
   assign accept      = out_en_i & ~out_empty_o;

   always_comb begin
      lane_r_en_o = '0;
      if (accept) begin
         lane_r_en_o[rd_ptr] = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_ptr <= '0;
      end else if (accept) begin
         if (rd_ptr == LAST_LANE) begin
            rd_ptr <= '0;
         end else begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // remember which RAM was read, its word shows up next cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_valid_q <= 1'b0;
         rd_lane_q  <= '0;
      end else begin
         rd_valid_q <= accept;
         if (accept) begin
            rd_lane_q <= rd_ptr;
         end
      end
   end

   assign out_data_o  = lane_r_data_i[rd_lane_q*lane_pkg::WORD_W +: lane_pkg::WORD_W];
   assign out_lane_o  = rd_lane_q;
   assign out_valid_o = rd_valid_q;

   // at most one strobe, and never into a lane flagged empty
   a_no_empty_read: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(lane_r_en_o) && ((lane_r_en_o & lane_empty_i) == '0))
      else $error("lane_collect: read strobe to empty lane");

endmodule

/* source/packer_top.sv */
`timescale 1ns/1ps

module packer_top (
   input  logic                                             clk_i,
   input  logic                                             rst_i,

   input  logic                                             in_valid_i,
   input  logic [lane_pkg::BYTE_W-1:0]                      in_data_i,
   output logic                                             in_full_o,

   input  logic                                             out_en_i,
   output logic [lane_pkg::WORD_W-1:0]                      out_data_o,
   output logic [lane_pkg::LANE_IDX_W-1:0]                  out_lane_o,
   output logic                                             out_valid_o,
   output logic                                             out_empty_o,

   output logic [lane_pkg::NUM_LANES*lane_pkg::LEVEL_W-1:0] level_o
);

   logic [lane_pkg::NUM_LANES-1:0]                  lane_w_en;
   logic [lane_pkg::BYTE_W-1:0]                     lane_w_data;
   logic [lane_pkg::NUM_LANES-1:0]                  lane_full;
   logic [lane_pkg::NUM_LANES-1:0]                  lane_r_en;
   logic [lane_pkg::NUM_LANES-1:0]                  lane_empty;
   logic [lane_pkg::NUM_LANES*lane_pkg::WORD_W-1:0] lane_r_data;

   lane_dispatch dispatch_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .in_valid_i    (in_valid_i),
      .in_data_i     (in_data_i),
      .in_full_o     (in_full_o),
      .lane_full_i   (lane_full),
      .lane_w_en_o   (lane_w_en),
      .lane_w_data_o (lane_w_data)
   );

   // bytes in, words out, lane 0 in the low slices
   for (genvar l = 0; l < lane_pkg::NUM_LANES; l++) begin : g_lane
      asym_fifo #(
         .W_DATA_W (lane_pkg::BYTE_W),
         .R_DATA_W (lane_pkg::WORD_W),
         .ADDR_W   (lane_pkg::FIFO_ADDR_W)
      ) fifo_i (
         .clk_i     (clk_i),
         .rst_i     (rst_i),
         .w_en_i    (lane_w_en[l]),
         .w_data_i  (lane_w_data),
         .w_full_o  (lane_full[l]),
         .r_en_i    (lane_r_en[l]),
         .r_data_o  (lane_r_data[l*lane_pkg::WORD_W +: lane_pkg::WORD_W]),
         .r_empty_o (lane_empty[l]),
         .level_o   (level_o[l*lane_pkg::LEVEL_W +: lane_pkg::LEVEL_W])
      );
   end

   lane_collect collect_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .out_en_i      (out_en_i),
      .out_empty_o   (out_empty_o),
      .out_data_o    (out_data_o),
      .out_lane_o    (out_lane_o),
      .out_valid_o   (out_valid_o),
      .lane_empty_i  (lane_empty),
      .lane_r_data_i (lane_r_data),
      .lane_r_en_o   (lane_r_en)
   );

endmodule

/* testbench/tb_packer_top.sv */
`timescale 1ns/1ps

module tb_packer_top;

   localparam int CLK_PERIOD = 20;
   localparam int RESET_CYCLES = 3;
   localparam int FILL_CYCLES = 800;
   localparam int DRAIN_CYCLES = 700;
   localparam int MIXED_CYCLES = 1500;
   localparam int TOTAL_CYCLES = RESET_CYCLES + FILL_CYCLES + DRAIN_CYCLES + MIXED_CYCLES;
   localparam int LANE_BYTES = 2 ** lane_pkg::FIFO_ADDR_W;
   localparam logic [31:0] SEED = 32'h616a_bbaa;

   logic                                             clk_i;
   logic                                             rst_i;
   logic                                             in_valid_i;
   logic [lane_pkg::BYTE_W-1:0]                      in_data_i;
   logic                                             in_full_o;
   logic                                             out_en_i;
   logic [lane_pkg::WORD_W-1:0]                      out_data_o;
   logic [lane_pkg::LANE_IDX_W-1:0]                  out_lane_o;
   logic                                             out_valid_o;
   logic                                             out_empty_o;
   logic [lane_pkg::NUM_LANES*lane_pkg::LEVEL_W-1:0] level_o;

   // reference model, one byte queue per lane
   logic [lane_pkg::BYTE_W-1:0]     lane_q [lane_pkg::NUM_LANES][$];
   logic [lane_pkg::WORD_W-1:0]     pend_word [$];
   logic [lane_pkg::LANE_IDX_W-1:0] pend_lane [$];
   int                              wr_ptr_m;
   int                              rd_ptr_m;
   logic                            exp_valid;
   logic                            last_read;

   int value_errs;
   int other_errs;
   int dropped_bytes;
   int ignored_reads;
   int back_to_back;

   packer_top packer_top_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .in_full_o   (in_full_o),
      .out_en_i    (out_en_i),
      .out_data_o  (out_data_o),
      .out_lane_o  (out_lane_o),
      .out_valid_o (out_valid_o),
      .out_empty_o (out_empty_o),
      .level_o     (level_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic check_word(input string name, input logic [lane_pkg::WORD_W-1:0] exp,
                             input logic [lane_pkg::WORD_W-1:0] act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
         value_errs++;
      end
   endtask

   task automatic check_lane(input string name, input logic [lane_pkg::LANE_IDX_W-1:0] exp,
                             input logic [lane_pkg::LANE_IDX_W-1:0] act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
         value_errs++;
      end
   endtask

   task automatic check_level(input string name, input logic [lane_pkg::LEVEL_W-1:0] exp,
                              input logic [lane_pkg::LEVEL_W-1:0] act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
         value_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
         value_errs++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("FAILURE: %s at %0t", what, $time);
      other_errs++;
   endtask

   // compare everything the DUT shows after the last edge
   task automatic check_outputs();
      logic [lane_pkg::WORD_W-1:0]     word;
      logic [lane_pkg::LANE_IDX_W-1:0] lane;
      for (int l = 0; l < lane_pkg::NUM_LANES; l++) begin
         check_level($sformatf("level_o[%0d]", l), lane_pkg::LEVEL_W'(lane_q[l].size()),
                     level_o[l*lane_pkg::LEVEL_W +: lane_pkg::LEVEL_W]);
      end
      check_flag("in_full_o", lane_q[wr_ptr_m].size() >= LANE_BYTES, in_full_o);
      check_flag("out_empty_o", lane_q[rd_ptr_m].size() < lane_pkg::BYTES_PER_WORD,
                 out_empty_o);
      check_flag("out_valid_o", exp_valid, out_valid_o);
      if (exp_valid) begin
         if (pend_word.size() == 0) begin
            report_failure("valid pulse expected but no read result is pending");
         end else begin
            word = pend_word.pop_front();
            lane = pend_lane.pop_front();
            if (out_valid_o) begin
               check_word("out_data_o", word, out_data_o);
               check_lane("out_lane_o", lane, out_lane_o);
            end
         end
      end
   endtask

   // apply one clock edge worth of accepted traffic to the model
   task automatic update_model(input logic acc_w, input logic acc_r,
                               input logic [lane_pkg::BYTE_W-1:0] data);
      logic [lane_pkg::WORD_W-1:0] word;
      exp_valid = acc_r;
      if (acc_r) begin
         if (lane_q[rd_ptr_m].size() < lane_pkg::BYTES_PER_WORD) begin
            report_failure("read accepted from a lane holding less than one word");
            exp_valid = 1'b0;
         end else begin
            word = '0;
            // first byte in goes to the low end
            for (int b = 0; b < lane_pkg::BYTES_PER_WORD; b++) begin
               word[b*lane_pkg::BYTE_W +: lane_pkg::BYTE_W] = lane_q[rd_ptr_m].pop_front();
            end
            pend_word.push_back(word);
            pend_lane.push_back(lane_pkg::LANE_IDX_W'(rd_ptr_m));
         end
         rd_ptr_m = (rd_ptr_m + 1) % lane_pkg::NUM_LANES;
      end
      if (acc_w) begin
         lane_q[wr_ptr_m].push_back(data);
         wr_ptr_m = (wr_ptr_m + 1) % lane_pkg::NUM_LANES;
      end
      if (acc_r && last_read) begin
         back_to_back++;
      end
      last_read = acc_r;
   endtask

   // rates in percent per cycle
   task automatic run_cycles(input int n, input int w_pct, input int r_pct);
      logic acc_w;
      logic acc_r;
      for (int c = 0; c < n; c++) begin
         @(negedge clk_i);
         check_outputs();
         in_valid_i = ($urandom % 100) < w_pct;
         in_data_i  = lane_pkg::BYTE_W'($urandom);
         out_en_i   = ($urandom % 100) < r_pct;
         // flags are registered, stable until the next rising edge
         acc_w = in_valid_i & ~in_full_o;
         acc_r = out_en_i & ~out_empty_o;
         if (in_valid_i && in_full_o) begin
            dropped_bytes++;
         end
         if (out_en_i && out_empty_o) begin
            ignored_reads++;
         end
         update_model(acc_w, acc_r, in_data_i);
      end
   endtask

   initial begin
      #(TOTAL_CYCLES * CLK_PERIOD * 2);
      $display("watchdog: run did not finish within %0d ns", TOTAL_CYCLES * CLK_PERIOD * 2);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      clk_i      = 1'b0;
      rst_i      = 1'b1;
      in_valid_i = 1'b0;
      in_data_i  = '0;
      out_en_i   = 1'b0;
      wr_ptr_m   = 0;
      rd_ptr_m   = 0;
      exp_valid  = 1'b0;
      last_read  = 1'b0;
      value_errs = 0;
      other_errs = 0;
      dropped_bytes = 0;
      ignored_reads = 0;
      back_to_back  = 0;

      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      // state straight out of reset
      check_outputs();

      run_cycles(FILL_CYCLES, 90, 5);
      run_cycles(DRAIN_CYCLES, 15, 95);
      run_cycles(MIXED_CYCLES, 60, 55);
      @(negedge clk_i);
      check_outputs();

      if (dropped_bytes == 0) begin
         report_failure("no byte was ever offered to a full lane");
      end
      if (ignored_reads == 0) begin
         report_failure("no read was ever requested from an empty lane");
      end
      if (back_to_back == 0) begin
         report_failure("no back-to-back reads were accepted");
      end

      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
source/lane_pkg.sv
source/ram_2p_asym.sv
source/asym_fifo.sv
source/lane_dispatch.sv
source/lane_collect.sv
source/packer_top.sv
testbench/tb_packer_top.sv

/* Bender.yml */
package:
  name: lane_packer

sources:
  - source/lane_pkg.sv
  - source/ram_2p_asym.sv
  - source/asym_fifo.sv
  - source/lane_dispatch.sv
  - source/lane_collect.sv
  - source/packer_top.sv
  - target: test
    files:
      - testbench/tb_packer_top.sv
